/* verif/program_trace.txt */
# P <byte address> <instruction word> loaded through the loader port
# E <expected output port word> in order, H <expected halted flag>
# setup x1=port, x2=-7, x3=3
P 00000000 000040B7
P 00000004 FF900113
P 00000008 00300193
# OP add sub sll slt sltu xor srl sra or and
P 0000000C 00310233
P 00000010 0040A023
P 00000014 40310233
P 00000018 0040A023
P 0000001C 00311233
P 00000020 0040A023
P 00000024 00312233
P 00000028 0040A023
P 0000002C 00313233
P 00000030 0040A023
P 00000034 00314233
P 00000038 0040A023
P 0000003C 00315233
P 00000040 0040A023
P 00000044 40315233
P 00000048 0040A023
P 0000004C 00316233
P 00000050 0040A023
P 00000054 00317233
P 00000058 0040A023
# OP-IMM srai sltiu xori
P 0000005C 40115213
P 00000060 0040A023
P 00000064 0041B213
P 00000068 0040A023
P 0000006C 00F14213
P 00000070 0040A023
# auipc lui jal jalr
P 00000074 00001217
P 00000078 0040A023
P 0000007C 12345237
P 00000080 0040A023
P 00000084 0080026F
P 00000088 00000213
P 0000008C 0040A023
P 00000090 01020267
P 00000094 00000213
P 00000098 0040A023
# branches, not-taken ones OR in a weight
P 0000009C 00000213
P 000000A0 00318463
P 000000A4 00126213
P 000000A8 00310463
P 000000AC 00226213
P 000000B0 00311463
P 000000B4 00426213
P 000000B8 00319463
P 000000BC 00826213
P 000000C0 00314463
P 000000C4 01026213
P 000000C8 0021C463
P 000000CC 02026213
P 000000D0 0040A023
P 000000D4 00000213
P 000000D8 00315463
P 000000DC 00126213
P 000000E0 0021D463
P 000000E4 00226213
P 000000E8 00316463
P 000000EC 00426213
P 000000F0 0021E463
P 000000F4 00826213
P 000000F8 0021F463
P 000000FC 01026213
P 00000100 00317463
P 00000104 02026213
P 00000108 0040A023
# memory at 0x200, byte and half merge then loads
P 0000010C 20000293
P 00000110 0002A023
P 00000114 00228023
P 00000118 003280A3
P 0000011C 00229123
P 00000120 0002A203
P 00000124 0040A023
P 00000128 00028203
P 0000012C 0040A023
P 00000130 0002C203
P 00000134 0040A023
P 00000138 00229203
P 0000013C 0040A023
P 00000140 0022D203
P 00000144 0040A023
P 00000148 00029203
P 0000014C 0040A023
# load from unmapped 0x8000 traps, store after it never runs
P 00000150 00008337
P 00000154 00032203
P 00000158 0040A023
E FFFFFFFC
E FFFFFFF6
E FFFFFFC8
E 00000001
E 00000000
E FFFFFFFA
E 1FFFFFFF
E FFFFFFFF
E FFFFFFFB
E 00000001
E FFFFFFFC
E 00000001
E FFFFFFF6
E 00001074
E 12345000
E 00000088
E 00000094
E 0000002A
E 00000015
E FFF903F9
E FFFFFFF9
E 000000F9
E FFFFFFF9
E 0000FFF9
E 000003F9
H 1

/* compile.f */
+incdir+hw
hw/otterPkg.sv
hw/busPkg.sv
hw/controlUnit.sv
hw/instDecoder.sv
hw/datapath.sv
hw/core.sv
hw/busFabric.sv
hw/otterSystem.sv
verif/otterAsserts.sv
verif/otterTb.sv

/* Makefile */
SRCS = $(wildcard hw/*.sv hw/*.svh verif/*.sv)

all: run

obj_dir/VotterTb: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module otterTb \
		--Mdir obj_dir -f compile.f

run: obj_dir/VotterTb verif/program_trace.txt
	./obj_dir/VotterTb | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* verif/otterTb.sv */
`timescale 1ns/1ps
`default_nettype none

module otterTb;

    logic        clk;
    logic        reset;
    logic        loadWrite;
    logic [31:0] loadAddr;
    logic [31:0] loadData;
    wire         ioStrobe;
    wire  [31:0] ioData;
    wire         halted;

    // Trace contents
    logic [31:0] progAddr [$];
    logic [31:0] progWord [$];
    logic [31:0] expIo [$];
    bit          expHalt;

    int          mismatchCount;
    int          otherCount;
    int          ioCount;
    int          cycles;
    int          cycleLimit;
    logic        running;

    otterSystem i_dut (
        .clk       (clk),
        .reset     (reset),
        .loadWrite (loadWrite),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .ioStrobe  (ioStrobe),
        .ioData    (ioData),
        .halted    (halted)
    );

    bind core otterAsserts asserts (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .halted (halted),
        .error  (error)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // Compare tasks
    task automatic checkIo(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            mismatchCount++;
            $display("Mismatch %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    task automatic checkHalt(input string name, input bit expected, input bit actual);
        if (actual !== expected) begin
            mismatchCount++;
            $display("Mismatch %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // Trace file parsing
    task automatic readTrace();
        int          fd;
        int          n;
        string       tag;
        string       rest;
        logic [31:0] a;
        logic [31:0] w;
        int          h;
        fd = $fopen("verif/program_trace.txt", "r");
        if (fd == 0) begin
            otherCount++;
            $display("Could not open the trace file verif/program_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1) begin
                break;
            end
            if (tag.getc(0) == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "P") begin
                n = $fscanf(fd, "%h %h", a, w);
                progAddr.push_back(a);
                progWord.push_back(w);
            end else if (tag == "E") begin
                n = $fscanf(fd, "%h", w);
                expIo.push_back(w);
            end else if (tag == "H") begin
                n = $fscanf(fd, "%d", h);
                expHalt = h[0];
            end else begin
                otherCount++;
                $display("Unknown record %s in the trace file", tag);
            end
        end
        $fclose(fd);
    endtask

    // Program words go in through the loader port
    task automatic loadProgram();
        for (int i = 0; i < progAddr.size(); i++) begin
            @(posedge clk);
            #1;
            loadWrite = 1'b1;
            loadAddr  = progAddr[i];
            loadData  = progWord[i];
        end
        @(posedge clk);
        #1;
        loadWrite = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
    endtask

    //////////////////////////////////////////////////
    // Output port monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (running && ioStrobe) begin
            if (expIo.size() == 0) begin
                otherCount++;
                $display("Unexpected output port write of %08h at cycle %0d", ioData, cycles);
            end else begin
                checkIo($sformatf("io write %0d", ioCount), expIo.pop_front(), ioData);
            end
            ioCount++;
        end
    end

    // Cycle counter and timeout
    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, the program did not finish", cycles);
            $display("Errors: mismatches %0d, other %0d", mismatchCount, otherCount + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        loadWrite     = 1'b0;
        loadAddr      = '0;
        loadData      = '0;
        running       = 1'b0;
        mismatchCount = 0;
        otherCount    = 0;
        ioCount       = 0;
        cycles        = 0;
        cycleLimit    = 0;
        expHalt       = 1'b0;

        readTrace();
        cycleLimit = 5 * progAddr.size() * 20;
        if (cycleLimit == 0) begin
            cycleLimit = 100;
        end

        // Reset for 5 cycles, then load while still in reset
        repeat (5) @(posedge clk);
        loadProgram();
        @(posedge clk);
        #1;
        reset   = 1'b0;
        running = 1'b1;

        // Run until halt, or until all writes are seen without halt expected
        while (!(halted === 1'b1 || (expIo.size() == 0 && !expHalt))) begin
            @(posedge clk);
        end

        // Window for stray port writes
        repeat (20) @(posedge clk);
        @(negedge clk);

        if (expIo.size() != 0) begin
            otherCount++;
            $display("Missing %0d expected output port writes", expIo.size());
        end
        checkHalt("halt flag", expHalt, halted);

        $display("Errors: mismatches %0d, other %0d", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/otterAsserts.sv */
`timescale 1ns/1ps
`default_nettype none

module otterAsserts import busPkg::*; (
    input wire logic   clk,
    input wire logic   reset,
    input wire busReqT req,
    input wire logic   halted,
    input wire logic   error
);

    //////////////////////////////////////////////////
    // Bus strobes

    // Never read and write in one cycle
    strobesExclusive: assert property (@(posedge clk) disable iff (reset)
        !(req.write && req.read))
        else $error("bus read and write strobes high together");

    // Strobe with error traps on the next cycle
    errorTraps: assert property (@(posedge clk) disable iff (reset)
        (error && (req.read || req.write)) |=> halted)
        else $error("bus error did not move the core to halt");

    //////////////////////////////////////////////////
    // Halt behaviour

    // Halt holds until reset
    haltSticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else $error("halted dropped without reset");

    // No bus traffic once halted
    haltQuiet: assert property (@(posedge clk) disable iff (reset)
        halted |-> !(req.read || req.write))
        else $error("bus strobe while halted");

endmodule

`default_nettype wire

/* hw/otterSystem.sv */
`timescale 1ns/1ps
`default_nettype none

module otterSystem import busPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        loadWrite,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData,
    output logic        ioStrobe,
    output logic [31:0] ioData,
    output logic        halted
);

    busReqT      coreReq;
    logic [31:0] rdata;
    logic        error;

    core core (
        .clk    (clk),
        .reset  (reset),
        .error  (error),
        .rdata  (rdata),
        .req    (coreReq),
        .halted (halted)
    );

    // Memory, output port and loader arbitration
    busFabric busFabric (
        .clk       (clk),
        .reset     (reset),
        .coreReq   (coreReq),
        .loadWrite (loadWrite),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .rdata     (rdata),
        .error     (error),
        .ioStrobe  (ioStrobe),
        .ioData    (ioData)
    );

endmodule

`default_nettype wire

/* hw/busFabric.sv */
`timescale 1ns/1ps
`default_nettype none
`include "otter_defs.svh"

module busFabric import busPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  busReqT      coreReq,
    input  logic        loadWrite,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData,
    output logic [31:0] rdata,
    output logic        error,
    output logic        ioStrobe,
    output logic [31:0] ioData
);

    localparam int idxBits = $clog2(`OTTER_MEM_WORDS);

    logic [31:0]        mem [`OTTER_MEM_WORDS];
    busReqT             req;
    logic [idxBits-1:0] idx;
    logic [3:0]         byteEn;
    logic               ramSel;
    logic               ioSel;
    logic [31:0]        portReg;
    logic [31:0]        portNext;

    //////////////////////////////////////////////////
    // Arbitration, loader wins
    always_comb begin
        if (loadWrite) begin
            req = '{write: 1'b1, read: 1'b0, size: sizeWord, addr: loadAddr, wdata: loadData};
        end else begin
            req = coreReq;
        end
    end

    // Address decode
    assign ramSel = req.addr[31:2] < `OTTER_MEM_WORDS;
    assign ioSel  = req.addr == `OTTER_IO_ADDR;
    assign idx    = req.addr[idxBits+1:2];

    // Refused core access or unmapped address
    assign error = (coreReq.write || coreReq.read) && (loadWrite || !(ramSel || ioSel));

    // Byte lanes from size and low address bits
    always_comb begin
        case (req.size)
            sizeByte: byteEn = 4'b0001 << req.addr[1:0];
            sizeHalf: byteEn = req.addr[1] ? 4'b1100 : 4'b0011;
            default:  byteEn = 4'b1111;
        endcase
    end

    //////////////////////////////////////////////////
    // RAM with registered read
    always_ff @(posedge clk) begin
        if (req.write && ramSel) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) begin
                    mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
        if (req.read) begin
            rdata <= ioSel ? portReg : mem[idx];
        end
    end

    // Output port, core writes only
    assign ioStrobe = !loadWrite && req.write && ioSel;

    always_comb begin
        portNext = portReg;
        for (int i = 0; i < 4; i++) begin
            if (byteEn[i]) begin
                portNext[8*i +: 8] = req.wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            portReg <= '0;
        end else if (ioStrobe) begin
            portReg <= portNext;
        end
    end

    // New value shows with the strobe
    assign ioData = ioStrobe ? portNext : portReg;

endmodule

`default_nettype wire

/* hw/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core import otterPkg::*; import busPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        error,
    input  logic [31:0] rdata,
    output busReqT      req,
    output logic        halted
);

    ctrlT        ctrl;
    aluOpT       aluOp;
    immKindT     immKind;
    instWordT    inst;
    logic        memWrite;
    logic        memRead;
    logic [31:0] addr;
    logic [31:0] wdata;

    controlUnit controlUnit (
        .clk      (clk),
        .reset    (reset),
        .opcode   (inst.r.opcode),
        .error    (error),
        .ctrl     (ctrl),
        .memWrite (memWrite),
        .memRead  (memRead),
        .halted   (halted)
    );

    instDecoder instDecoder (
        .inst    (inst),
        .aluCtrl (ctrl.aluCtrl),
        .aluOp   (aluOp),
        .immKind (immKind)
    );

    datapath datapath (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .aluOp   (aluOp),
        .immKind (immKind),
        .rdata   (rdata),
        .inst    (inst),
        .addr    (addr),
        .wdata   (wdata)
    );

    // Bus request
    assign req.write = memWrite;
    assign req.read  = memRead;
    // Fetches are always whole words
    assign req.size  = ctrl.addrSrc ? accessSizeT'(inst.r.funct3[1:0]) : sizeWord;
    assign req.addr  = addr;
    assign req.wdata = wdata;

endmodule

`default_nettype wire

/* hw/datapath.sv */
`timescale 1ns/1ps
`default_nettype none
`include "otter_defs.svh"

module datapath import otterPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  ctrlT        ctrl,
    input  aluOpT       aluOp,
    input  immKindT     immKind,
    input  logic [31:0] rdata,
    output instWordT    inst,
    output logic [31:0] addr,
    output logic [31:0] wdata
);

    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] target;
    logic [31:0] imm;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] aluReg;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] regData;
    logic [31:0] loadWord;
    logic [31:0] loadData;
    logic [31:0] regFile [32];
    logic        branchTaken;
    logic        takeTarget;

    //////////////////////////////////////////////////
    // PC and instruction register
    assign pcPlus4    = pc + 32'd4;
    // Low bit cleared for JALR
    assign target     = {aluResult[31:1], 1'b0};
    assign takeTarget = ctrl.enBranch && (inst.b.opcode != opBranch || branchTaken);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `OTTER_RESET_PC;
        end else if (ctrl.pcUpdate) begin
            pc <= takeTarget ? target : pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            inst <= rdata;
        end
        aluReg <= aluResult;
    end

    // Bus address and store lane
    assign addr  = ctrl.addrSrc ? aluReg : pc;
    assign wdata = rs2Data << {aluReg[1:0], 3'b000};

    //////////////////////////////////////////////////
    // Register file with x0 tied to zero
    assign rs1Data = (inst.r.rs1 == 5'd0) ? '0 : regFile[inst.r.rs1];
    assign rs2Data = (inst.r.rs2 == 5'd0) ? '0 : regFile[inst.r.rs2];

    always_comb begin
        case (ctrl.regSrc)
            wbLoad:  regData = loadData;
            wbLink:  regData = pcPlus4;
            default: regData = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.regWrite && inst.r.rd != 5'd0) begin
            regFile[inst.r.rd] <= regData;
        end
    end

    // Immediates
    always_comb begin
        case (immKind)
            immS: imm = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
            immB: imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                         inst.b.imm10to5, inst.b.imm4to1, 1'b0};
            immU: imm = {inst.u.imm, 12'b0};
            immJ: imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19to12,
                         inst.j.imm11, inst.j.imm10to1, 1'b0};
            default: imm = {{20{inst.i.imm[11]}}, inst.i.imm};
        endcase
    end

    //////////////////////////////////////////////////
    // ALU
    assign aluA = (ctrl.aluSrcA == srcAPc) ? pc : rs1Data;
    assign aluB = (ctrl.aluSrcB == srcBRs2) ? rs2Data : imm;

    always_comb begin
        case (aluOp)
            aluSub:   aluResult = aluA - aluB;
            aluSll:   aluResult = aluA << aluB[4:0];
            aluSlt:   aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
            aluSltu:  aluResult = {31'b0, aluA < aluB};
            aluXor:   aluResult = aluA ^ aluB;
            aluSrl:   aluResult = aluA >> aluB[4:0];
            aluSra:   aluResult = $signed(aluA) >>> aluB[4:0];
            aluOr:    aluResult = aluA | aluB;
            aluAnd:   aluResult = aluA & aluB;
            aluPassB: aluResult = aluB;
            default:  aluResult = aluA + aluB;
        endcase
    end

    // Branch compare by funct3
    always_comb begin
        case (inst.b.funct3)
            3'b000:  branchTaken = rs1Data == rs2Data;
            3'b001:  branchTaken = rs1Data != rs2Data;
            3'b100:  branchTaken = $signed(rs1Data) < $signed(rs2Data);
            3'b101:  branchTaken = $signed(rs1Data) >= $signed(rs2Data);
            3'b110:  branchTaken = rs1Data < rs2Data;
            3'b111:  branchTaken = rs1Data >= rs2Data;
            default: branchTaken = 1'b0;
        endcase
    end

    // Load lane shift and extension
    assign loadWord = rdata >> {aluReg[1:0], 3'b000};

    always_comb begin
        case (inst.i.funct3)
            3'b000:  loadData = {{24{loadWord[7]}}, loadWord[7:0]};
            3'b001:  loadData = {{16{loadWord[15]}}, loadWord[15:0]};
            3'b100:  loadData = {24'b0, loadWord[7:0]};
            3'b101:  loadData = {16'b0, loadWord[15:0]};
            default: loadData = loadWord;
        endcase
    end

endmodule

`default_nettype wire

/* hw/instDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instDecoder import otterPkg::*; (
    input  instWordT inst,
    input  logic     aluCtrl,
    output aluOpT    aluOp,
    output immKindT  immKind
);

    // ALU operation
    always_comb begin
        aluOp = aluAdd;
        if (inst.r.opcode == opLui) begin
            aluOp = aluPassB;
        end else if (aluCtrl) begin
            // OP-IMM only looks at funct7 for the right shifts
            if (inst.r.opcode == opReg || inst.r.funct3 == 3'b101) begin
                aluOp = aluOpT'({inst.r.funct7[5], inst.r.funct3});
            end else begin
                aluOp = aluOpT'({1'b0, inst.r.funct3});
            end
        end
    end

    // Immediate format by opcode
    always_comb begin
        case (inst.r.opcode)
            opStore:  immKind = immS;
            opBranch: immKind = immB;
            opLui:    immKind = immU;
            opAuipc:  immKind = immU;
            opJal:    immKind = immJ;
            // JALR, loads and OP-IMM
            default:  immKind = immI;
        endcase
    end

endmodule

`default_nettype wire

/* hw/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit import otterPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  opcodeT opcode,
    input  logic   error,
    output ctrlT   ctrl,
    output logic   memWrite,
    output logic   memRead,
    output logic   halted
);

    typedef enum logic [2:0] {stFetch, stDecode, stExecute, stMemory, stLoadWb, stHalt} stateT;

    stateT state;
    stateT nextState;
    logic  isLoad;
    logic  isStore;
    logic  isJump;
    logic  writesAlu;

    assign isLoad    = opcode == opLoad;
    assign isStore   = opcode == opStore;
    assign isJump    = (opcode == opJal) || (opcode == opJalr);
    assign writesAlu = (opcode == opReg) || (opcode == opImm) ||
                       (opcode == opLui) || (opcode == opAuipc);
    assign halted    = state == stHalt;

    //////////////////////////////////////////////////
    // Sequencer
    always_comb begin
        nextState = state;
        case (state)
            // First fetch after reset waits one cycle for the read strobe
            stFetch:   nextState = memRead ? stDecode : stFetch;
            stDecode:  nextState = stExecute;
            stExecute: nextState = (isLoad || isStore) ? stMemory : stFetch;
            stMemory:  nextState = isLoad ? stLoadWb : stFetch;
            stLoadWb:  nextState = stFetch;
            default:   nextState = stHalt;
        endcase
        // Bus error on any strobe traps
        if ((memRead || memWrite) && error) begin
            nextState = stHalt;
        end
    end

    // Strobes registered against the state being entered
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= stFetch;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
        end else begin
            state    <= nextState;
            memRead  <= (nextState == stFetch) || ((nextState == stMemory) && isLoad);
            memWrite <= (nextState == stMemory) && isStore;
        end
    end

    //////////////////////////////////////////////////
    // Datapath controls
    always_comb begin
        ctrl = '0;
        // Operand selects follow the opcode in every state
        ctrl.aluSrcA = (opcode == opAuipc || opcode == opJal || opcode == opBranch) ?
                       srcAPc : srcARs1;
        ctrl.aluSrcB = (opcode == opReg) ? srcBRs2 : srcBImm;
        ctrl.aluCtrl = (opcode == opReg) || (opcode == opImm);
        if (isLoad) begin
            ctrl.regSrc = wbLoad;
        end else if (isJump) begin
            ctrl.regSrc = wbLink;
        end else begin
            ctrl.regSrc = wbAlu;
        end
        case (state)
            stDecode: ctrl.irWrite = 1'b1;
            stExecute: begin
                ctrl.enBranch = isJump || (opcode == opBranch);
                ctrl.regWrite = writesAlu || isJump;
                ctrl.pcUpdate = !(isLoad || isStore);
            end
            stMemory: begin
                // Address comes from the registered ALU result
                ctrl.addrSrc  = 1'b1;
                ctrl.pcUpdate = isStore;
            end
            stLoadWb: begin
                ctrl.regWrite = 1'b1;
                ctrl.pcUpdate = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/busPkg.sv */
`default_nettype none

package busPkg;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSizeT;

    // One request on the shared bus
    typedef struct packed {
        logic        write;
        logic        read;
        accessSizeT  size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } busReqT;

endpackage

`default_nettype wire

/* hw/otterPkg.sv */
`default_nettype none

package otterPkg;

    // Supported RV32I major opcodes
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011
    } opcodeT;

    // Encoded as {funct7[5], funct3} so the decoder can cast directly
    typedef enum logic [3:0] {
        aluAdd   = 4'b0000,
        aluSub   = 4'b1000,
        aluSll   = 4'b0001,
        aluSlt   = 4'b0010,
        aluSltu  = 4'b0011,
        aluXor   = 4'b0100,
        aluSrl   = 4'b0101,
        aluSra   = 4'b1101,
        aluOr    = 4'b0110,
        aluAnd   = 4'b0111,
        aluPassB = 4'b1001
    } aluOpT;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immKindT;

    //////////////////////////////////////////////////
    // Instruction formats, all views of one word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        opcodeT     opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        opcodeT     opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcodeT      opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        opcodeT     opcode;
    } jTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instWordT;

    //////////////////////////////////////////////////
    // Per-cycle datapath controls
    typedef struct packed {
        logic       pcUpdate;
        logic       irWrite;
        logic       addrSrc;
        logic       regWrite;
        logic [1:0] regSrc;
        logic [1:0] aluSrcA;
        logic [1:0] aluSrcB;
        logic       aluCtrl;
        logic       enBranch;
    } ctrlT;

    // Mux select encodings
    localparam logic [1:0] srcARs1 = 2'd0;
    localparam logic [1:0] srcAPc  = 2'd1;
    localparam logic [1:0] srcBRs2 = 2'd0;
    localparam logic [1:0] srcBImm = 2'd1;
    localparam logic [1:0] wbAlu   = 2'd0;
    localparam logic [1:0] wbLoad  = 2'd1;
    localparam logic [1:0] wbLink  = 2'd2;

endpackage

`default_nettype wire

/* hw/otter_defs.svh */
`ifndef OTTER_DEFS_SVH
`define OTTER_DEFS_SVH

// RAM depth in 32-bit words
`define OTTER_MEM_WORDS 1024

// Byte address of the output port
`define OTTER_IO_ADDR 32'h0000_4000

// First fetch address out of reset
`define OTTER_RESET_PC 32'h0000_0000

`endif
